//--- offload_arbiter.sv
// ----------------------------------------------------------
// Offload response arbiter
// Round-robin merge of the unit responses, grant locked
// while the output is stalled
// ----------------------------------------------------------

`timescale 1ns/1ps

module offload_arbiter (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  offload_pkg::acc_rsp_t [offload_pkg::NumUnits-1:0] rsp_i,
  input  offload_pkg::unit_vec_t                           valid_i,
  output offload_pkg::unit_vec_t                           ready_o,
  output offload_pkg::acc_rsp_t                            rsp_o,
  output logic                                            valid_o,
  input  logic                                            ready_i
);

  import offload_pkg::*;

  unit_sel_t ptr_q;
  unit_sel_t gnt_q;
  logic      lock_q;
  unit_sel_t pick;
  logic      any_valid;
  unit_sel_t gnt_idx;
  unit_sel_t cand;

  // ----------------------------------------------------------
  // Selection
  // ----------------------------------------------------------
  // First valid unit at or after the priority pointer
  always_comb begin
    pick      = ptr_q;
    any_valid = 1'b0;
    cand      = ptr_q;
    for (int unsigned i = 0; i < NumUnits; i++) begin
      cand = unit_sel_t'(ptr_q + i);
      if (!any_valid && valid_i[cand]) begin
        pick      = cand;
        any_valid = 1'b1;
      end
    end
  end

  // Locked grant wins over a fresh pick
  assign gnt_idx = lock_q ? gnt_q : pick;
  assign valid_o = lock_q ? valid_i[gnt_q] : any_valid;
  assign rsp_o   = rsp_i[gnt_idx];

  // Ready goes back to the granted unit only
  always_comb begin
    ready_o = '0;
    ready_o[gnt_idx] = valid_o & ready_i;
  end

  // ----------------------------------------------------------
  // Pointer and lock
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q  <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else if (valid_o && ready_i) begin
      lock_q <= 1'b0;
      ptr_q  <= gnt_idx + 1'b1;
    end else if (valid_o) begin
      lock_q <= 1'b1;
      gnt_q  <= gnt_idx;
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(ready_o))
    else $error("arbiter grants more than one unit");

  // The locked unit keeps its response up
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lock_q |-> valid_i[gnt_q])
    else $error("locked unit withdrew its response");

endmodule

//--- offload_cc.sv
// ----------------------------------------------------------
// Offload core complex
// Dispatch stage, four integer units and response arbiter
// ----------------------------------------------------------

`timescale 1ns/1ps

module offload_cc (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  offload_pkg::acc_req_t q_req_i,
  input  logic                 q_valid_i,
  output logic                 q_ready_o,
  output offload_pkg::acc_rsp_t p_rsp_o,
  output logic                 p_valid_o,
  input  logic                 p_ready_i
);

  import offload_pkg::*;

  // Dispatch to units
  acc_req_t  unit_req;
  unit_vec_t unit_qvalid;
  unit_vec_t unit_qready;

  // Units to arbiter
  acc_rsp_t [NumUnits-1:0] unit_rsp;
  unit_vec_t               unit_pvalid;
  unit_vec_t               unit_pready;

  offload_dispatch i_dispatch (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .req_i        ( q_req_i     ),
    .valid_i      ( q_valid_i   ),
    .ready_o      ( q_ready_o   ),
    .unit_req_o   ( unit_req    ),
    .unit_valid_o ( unit_qvalid ),
    .unit_ready_i ( unit_qready )
  );

  for (genvar i = 0; i < NumUnits; i++) begin : gen_units
    offload_unit i_unit (
      .clk_i     ( clk_i          ),
      .rst_ni    ( rst_ni         ),
      .req_i     ( unit_req       ),
      .q_valid_i ( unit_qvalid[i] ),
      .q_ready_o ( unit_qready[i] ),
      .rsp_o     ( unit_rsp[i]    ),
      .p_valid_o ( unit_pvalid[i] ),
      .p_ready_i ( unit_pready[i] )
    );
  end

  offload_arbiter i_arbiter (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .rsp_i   ( unit_rsp    ),
    .valid_i ( unit_pvalid ),
    .ready_o ( unit_pready ),
    .rsp_o   ( p_rsp_o     ),
    .valid_o ( p_valid_o   ),
    .ready_i ( p_ready_i   )
  );

endmodule

//--- offload_dispatch.sv
// ----------------------------------------------------------
// Offload dispatch stage
// Holds one request and steers it to the unit named by addr
// ----------------------------------------------------------

`timescale 1ns/1ps

module offload_dispatch (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  offload_pkg::acc_req_t  req_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output offload_pkg::acc_req_t  unit_req_o,
  output offload_pkg::unit_vec_t unit_valid_o,
  input  offload_pkg::unit_vec_t unit_ready_i
);

  import offload_pkg::*;

  acc_req_t req_q;
  logic     full_q;
  logic     leaving;
  logic     accept;

  // ----------------------------------------------------------
  // Steering
  // ----------------------------------------------------------
  // One-hot valid from the held address
  always_comb begin
    unit_valid_o = '0;
    if (full_q) begin
      unit_valid_o[req_q.addr] = 1'b1;
    end
  end

  // All units see the same payload
  assign unit_req_o = req_q;

  // Held request is taken by its unit this cycle
  assign leaving = |(unit_valid_o & unit_ready_i);

  assign ready_o = ~full_q | leaving;
  assign accept  = valid_i & ready_o;

  // ----------------------------------------------------------
  // Stage register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      // Refill on accept or drain
      full_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // Never more than one unit addressed
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(unit_valid_o))
    else $error("dispatch drives more than one unit valid");

endmodule

//--- offload_pkg.sv
// ----------------------------------------------------------
// Offload fabric package
// Widths, operation codes and the request/response payloads
// shared by the dispatch stage, the units and the arbiter
// ----------------------------------------------------------

package offload_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  localparam int unsigned UnitSelWidth = 2;
  // One unit per unit-select code
  localparam int unsigned NumUnits     = 1 << UnitSelWidth;
  localparam int unsigned IdWidth      = 5;
  localparam int unsigned DataWidth    = 32;

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------
  // Target unit index
  typedef logic [UnitSelWidth-1:0] unit_sel_t;
  // Tag returned with the response
  typedef logic [IdWidth-1:0]      acc_id_t;
  // Operand or result word
  typedef logic [DataWidth-1:0]    data_t;
  // One valid or ready bit per unit
  typedef logic [NumUnits-1:0]     unit_vec_t;

  // Integer operation set, codes 11 to 15 are undefined
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    MUL  = 4'd8,
    SLT  = 4'd9,
    SLTU = 4'd10
  } acc_op_e;

  // ----------------------------------------------------------
  // Payloads
  // ----------------------------------------------------------
  typedef struct packed {
    unit_sel_t addr;
    acc_id_t   id;
    acc_op_e   op;
    data_t     arga;
    data_t     argb;
  } acc_req_t;

  typedef struct packed {
    acc_id_t id;
    data_t   data;
    logic    error;
  } acc_rsp_t;

endpackage

//--- offload_unit.sv
// ----------------------------------------------------------
// Offload integer execution unit
// One request at a time, result kept in a one-entry register
// ----------------------------------------------------------

`timescale 1ns/1ps

module offload_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  offload_pkg::acc_req_t req_i,
  input  logic                 q_valid_i,
  output logic                 q_ready_o,
  output offload_pkg::acc_rsp_t rsp_o,
  output logic                 p_valid_o,
  input  logic                 p_ready_i
);

  import offload_pkg::*;

  logic [4:0] shamt;
  data_t      product;
  logic       lt_signed;
  logic       lt_unsigned;
  acc_rsp_t   rsp_d;
  acc_rsp_t   rsp_q;
  logic       valid_q;

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------
  assign shamt       = req_i.argb[4:0];
  // Low word of the product only
  assign product     = req_i.arga * req_i.argb;
  assign lt_signed   = $signed(req_i.arga) < $signed(req_i.argb);
  assign lt_unsigned = req_i.arga < req_i.argb;

  always_comb begin
    rsp_d.id    = req_i.id;
    rsp_d.data  = '0;
    rsp_d.error = 1'b0;
    case (req_i.op)
      ADD:  rsp_d.data = req_i.arga + req_i.argb;
      SUB:  rsp_d.data = req_i.arga - req_i.argb;
      AND:  rsp_d.data = req_i.arga & req_i.argb;
      OR:   rsp_d.data = req_i.arga | req_i.argb;
      XOR:  rsp_d.data = req_i.arga ^ req_i.argb;
      SLL:  rsp_d.data = req_i.arga << shamt;
      SRL:  rsp_d.data = req_i.arga >> shamt;
      SRA:  rsp_d.data = data_t'($signed(req_i.arga) >>> shamt);
      MUL:  rsp_d.data = product;
      SLT:  rsp_d.data = data_t'(lt_signed);
      SLTU: rsp_d.data = data_t'(lt_unsigned);
      // Undefined code returns zero with the error flag
      default: rsp_d.error = 1'b1;
    endcase
  end

  // ----------------------------------------------------------
  // Result register
  // ----------------------------------------------------------
  // Free when empty or when the result leaves now
  assign q_ready_o = ~valid_q | p_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (q_ready_o) begin
      valid_q <= q_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (q_valid_i && q_ready_o) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o     = rsp_q;
  assign p_valid_o = valid_q;

  // Stalled response holds valid and payload
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (p_valid_o && !p_ready_i) |=> (p_valid_o && $stable(rsp_o)))
    else $error("unit response changed while stalled");

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the offload testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log" build.log

verilator --binary --timing --assert --top-module tb_offload_cc -f sim.f \
  -o tb_offload_cc > build.log 2>&1 \
  && ./obj_dir/tb_offload_cc > "$log" 2>&1 \
  || { cat build.log "$log" 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat "$log"
grep -q "Finished with errors" "$log" \
  && { echo "FAIL"; exit 1; } \
  || { echo "PASS"; exit 0; }

//--- sim.f
offload_pkg.sv
offload_dispatch.sv
offload_unit.sv
offload_arbiter.sv
offload_cc.sv
tb_offload_cc.sv

//--- tb_offload_cc.sv
// ----------------------------------------------------------
// Testbench for the offload core complex
// Directed and random requests against a reference model
// with random back-pressure on the response port
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_offload_cc;

  import offload_pkg::*;

  localparam int unsigned NumReqs   = 300;
  localparam int unsigned MaxCycles = 20 * NumReqs + 200;
  localparam int unsigned NumIds    = 1 << IdWidth;

  logic     clk;
  logic     rst_n;
  acc_req_t q_req;
  logic     q_valid;
  logic     q_ready;
  acc_rsp_t p_rsp;
  logic     p_valid;
  logic     p_ready;
  logic     bp_en;

  // Scoreboard state, written by the checking process only
  acc_rsp_t  exp_rsp [NumIds];
  unit_sel_t id_unit [NumIds];
  logic      in_flight [NumIds];
  acc_id_t   unit_ids [NumUnits][$];
  int        outstanding = 0;
  int        issued = 0;
  int        received = 0;
  int        errors = 0;
  int        order_errors = 0;

  int        idle_errors = 0;
  int        tests_done = 0;
  int        seed = 32'hc2e0;
  acc_id_t   next_id;
  string     test_name;

  offload_cc dut (
    .clk_i     ( clk     ),
    .rst_ni    ( rst_n   ),
    .q_req_i   ( q_req   ),
    .q_valid_i ( q_valid ),
    .q_ready_o ( q_ready ),
    .p_rsp_o   ( p_rsp   ),
    .p_valid_o ( p_valid ),
    .p_ready_i ( p_ready )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------------------------
  function automatic acc_rsp_t ref_result(acc_req_t req);
    acc_rsp_t    rsp;
    logic [4:0]  sh;
    logic [63:0] ext;
    logic [63:0] prod;
    sh        = req.argb[4:0];
    ext       = {{32{req.arga[31]}}, req.arga};
    prod      = {32'b0, req.arga} * {32'b0, req.argb};
    rsp.id    = req.id;
    rsp.data  = '0;
    rsp.error = 1'b0;
    case (req.op)
      ADD:  rsp.data = req.arga + req.argb;
      SUB:  rsp.data = req.arga + ~req.argb + 32'd1;
      AND:  rsp.data = req.arga & req.argb;
      OR:   rsp.data = req.arga | req.argb;
      XOR:  rsp.data = req.arga ^ req.argb;
      SLL:  rsp.data = req.arga << sh;
      SRL:  rsp.data = req.arga >> sh;
      SRA:  rsp.data = data_t'(ext >> sh);
      MUL:  rsp.data = prod[31:0];
      // Differing signs are decided by the sign of arga
      SLT:  rsp.data = data_t'((req.arga[31] != req.argb[31]) ? req.arga[31]
                                                               : req.arga < req.argb);
      SLTU: rsp.data = data_t'(req.arga < req.argb);
      default: rsp.error = 1'b1;
    endcase
    return rsp;
  endfunction

  task automatic check_data(string what, data_t exp_val, data_t act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
    end
  endtask

  task automatic check_flag(string what, logic exp_val, logic act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp_val, act_val);
    end
  endtask

  // Checking process samples at the falling edge where all signals are settled
  initial begin
    acc_req_t req;
    acc_rsp_t rsp;
    acc_id_t  first;
    foreach (in_flight[i]) begin
      in_flight[i] = 1'b0;
    end
    forever begin
      @(negedge clk);
      if (rst_n && p_valid && p_ready) begin
        rsp = p_rsp;
        received++;
        if (!in_flight[rsp.id]) begin
          errors++;
          $display("%s: response id %0d was not in flight, duplicated or never issued",
                   test_name, rsp.id);
        end else begin
          check_data($sformatf("id %0d data", rsp.id), exp_rsp[rsp.id].data, rsp.data);
          check_flag($sformatf("id %0d error", rsp.id), exp_rsp[rsp.id].error, rsp.error);
          first = unit_ids[id_unit[rsp.id]].pop_front();
          if (first != rsp.id) begin
            errors++;
            order_errors++;
            $display("%s: unit %0d returned id %0d ahead of id %0d issued before it",
                     test_name, id_unit[rsp.id], rsp.id, first);
          end
          in_flight[rsp.id] = 1'b0;
          outstanding--;
        end
      end
      if (rst_n && q_valid && q_ready) begin
        req               = q_req;
        exp_rsp[req.id]   = ref_result(req);
        id_unit[req.id]   = req.addr;
        in_flight[req.id] = 1'b1;
        unit_ids[req.addr].push_back(req.id);
        outstanding++;
        issued++;
      end
    end
  end

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  function automatic int unsigned rand_below(int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic data_t rand_word();
    return data_t'($random(seed));
  endfunction

  // Hold one request until the DUT takes it
  task automatic send_req(unit_sel_t unit, acc_op_e op, data_t a, data_t b);
    logic taken;
    taken = 1'b0;
    while (in_flight[next_id]) begin
      @(posedge clk);
      #1;
    end
    q_req.addr = unit;
    q_req.id   = next_id;
    q_req.op   = op;
    q_req.arga = a;
    q_req.argb = b;
    q_valid    = 1'b1;
    while (!taken) begin
      @(negedge clk);
      taken = q_ready;
      @(posedge clk);
      #1;
    end
    q_valid = 1'b0;
    next_id = next_id + 1'b1;
  endtask

  task automatic random_traffic(int count);
    logic [3:0] code;
    repeat (count) begin
      code = 4'(rand_below(11));
      send_req(unit_sel_t'(rand_below(NumUnits)), acc_op_e'(code),
               rand_word(), rand_word());
    end
  endtask

  task automatic drain();
    while (outstanding != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report_test(int errs_before);
    tests_done++;
    $display("test %s done: %0d errors", test_name, errors + idle_errors - errs_before);
  endtask

  // Response back-pressure, drawn at the falling edge and applied after the rising edge
  initial begin
    logic bp_next;
    p_ready = 1'b1;
    forever begin
      @(negedge clk);
      bp_next = bp_en ? (rand_below(3) != 0) : 1'b1;
      @(posedge clk);
      #1;
      p_ready = bp_next;
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d responses outstanding", cycles, outstanding);
    $display("Finished with errors");
    $finish;
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    data_t edge_a [4];
    data_t edge_b [4];
    int    errs;
    edge_a  = '{32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h00000001};
    edge_b  = '{32'h80000000, 32'h00000025, 32'hffffffff, 32'h0000001f};
    rst_n   = 1'b0;
    q_valid = 1'b0;
    q_req   = '0;
    bp_en   = 1'b0;
    next_id = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_name = "reset_idle";
    errs = errors + idle_errors;
    repeat (3) begin
      @(negedge clk);
      if (p_valid !== 1'b0) begin
        idle_errors++;
        $display("reset_idle: p_valid_o is high before any request was sent");
      end
    end
    @(posedge clk);
    #1;
    report_test(errs);

    // Every defined operation on every unit with edge and random operands
    test_name = "directed_ops";
    errs = errors + idle_errors;
    for (int op = 0; op < 11; op++) begin
      for (int u = 0; u < 4; u++) begin
        send_req(unit_sel_t'(u), acc_op_e'(4'(op)), edge_a[u], edge_b[u]);
        send_req(unit_sel_t'(u), acc_op_e'(4'(op)), edge_a[3-u], rand_word());
        send_req(unit_sel_t'(u), acc_op_e'(4'(op)), rand_word(), rand_word());
      end
    end
    drain();
    report_test(errs);

    // Undefined codes each followed by a normal request to the same unit
    test_name = "undefined_ops";
    errs = errors + idle_errors;
    for (int code = 11; code < 16; code++) begin
      send_req(unit_sel_t'(code % 4), acc_op_e'(4'(code)), rand_word(), rand_word());
      send_req(unit_sel_t'(code % 4), ADD, rand_word(), rand_word());
    end
    drain();
    report_test(errs);

    test_name = "random_free";
    errs = errors + idle_errors;
    random_traffic(79);
    drain();
    report_test(errs);

    test_name = "random_backpressure";
    errs = errors + idle_errors;
    bp_en = 1'b1;
    random_traffic(79);
    drain();
    bp_en = 1'b0;
    report_test(errs);

    // Order was checked on every response above
    test_name = "issue_order";
    tests_done++;
    $display("test %s done: %0d errors", test_name, order_errors);

    if (issued != NumReqs || received != issued) begin
      idle_errors++;
      $display("request count wrong: %0d issued, %0d received", issued, received);
    end
    $display("tests %0d, requests %0d, responses %0d, errors %0d",
             tests_done, issued, received, errors + idle_errors);
    if (errors + idle_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
